// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fixed_logsigmoid
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/act_format_pkg.sv
package act_format_pkg;

  // ##############################
  // Element format
  // ##############################

  // Signed Q4.4 activation element.
  localparam int ACT_WIDTH = 8;
  localparam int ACT_FRAC = 4;

  // One element as stored on the stream, two's complement bit pattern.
  typedef logic [ACT_WIDTH-1:0] act_t;

  // ##############################
  // Saturation bounds
  // ##############################

  // Most negative and most positive codes.
  localparam int ACT_MIN = -(2 ** (ACT_WIDTH - 1));
  localparam int ACT_MAX = (2 ** (ACT_WIDTH - 1)) - 1;

  // Number of distinct codes, one table entry each.
  localparam int LUT_SIZE = 2 ** ACT_WIDTH;

endpackage

// File: design/fixed_logsigmoid.sv
`timescale 1ns/1ps

module fixed_logsigmoid (
  input  logic                  clk,
  input  logic                  rst,
  input  stream_pkg::in_beat_t  in_beat,
  input  logic                  in_valid,
  output logic                  in_ready,
  output stream_pkg::out_beat_t out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);

  // FIFO to roller.
  stream_pkg::in_beat_t  fifo_beat;
  logic                  fifo_valid;
  logic                  fifo_ready;

  // Roller to lookup stage.
  stream_pkg::out_beat_t roll_beat;
  logic                  roll_valid;
  logic                  roll_ready;

  unpacked_fifo #(
    .DEPTH (stream_pkg::FIFO_DEPTH)
  ) roller_buffer (
    .clk            (clk),
    .rst            (rst),
    .data_in        (in_beat),
    .data_in_valid  (in_valid),
    .data_in_ready  (in_ready),
    .data_out       (fifo_beat),
    .data_out_valid (fifo_valid),
    .data_out_ready (fifo_ready)
  );

  roller roller_inst (
    .clk            (clk),
    .rst            (rst),
    .data_in        (fifo_beat),
    .data_in_valid  (fifo_valid),
    .data_in_ready  (fifo_ready),
    .data_out       (roll_beat),
    .data_out_valid (roll_valid),
    .data_out_ready (roll_ready)
  );

  logsigmoid_lut logsigmoid_map (
    .clk            (clk),
    .rst            (rst),
    .data_in        (roll_beat),
    .data_in_valid  (roll_valid),
    .data_in_ready  (roll_ready),
    .data_out       (out_beat),
    .data_out_valid (out_valid),
    .data_out_ready (out_ready)
  );

endmodule

// File: design/logsigmoid_lut.sv
`timescale 1ns/1ps

module logsigmoid_lut (
  input  logic                  clk,
  input  logic                  rst,
  input  stream_pkg::out_beat_t data_in,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output stream_pkg::out_beat_t data_out,
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  localparam int LUT_SIZE = act_format_pkg::LUT_SIZE;
  localparam int SCALE = 1 << act_format_pkg::ACT_FRAC;

  typedef logic [LUT_SIZE-1:0][act_format_pkg::ACT_WIDTH-1:0] lut_t;

  // ##############################
  // Table build
  // ##############################

  // Entry per code, log(sigmoid(x)) in the same Q4.4 format.
  function automatic lut_t build_lut();
    lut_t lut_v;
    logic signed [act_format_pkg::ACT_WIDTH-1:0] code;
    real x;
    real y;
    int r;
    for (int i = 0; i < LUT_SIZE; i++) begin
      code = act_format_pkg::act_t'(i);
      x = $itor(code) / $itor(SCALE);
      y = -$ln(1.0 + $exp(-x)) * $itor(SCALE);
      // Halves round away from zero.
      r = (y < 0.0) ? $rtoi(y - 0.5) : $rtoi(y + 0.5);
      if (r < act_format_pkg::ACT_MIN) r = act_format_pkg::ACT_MIN;
      else if (r > act_format_pkg::ACT_MAX) r = act_format_pkg::ACT_MAX;
      lut_v[i] = act_format_pkg::act_t'(r);
    end
    return lut_v;
  endfunction

  localparam lut_t LUT = build_lut();

  // ##############################
  // Output register
  // ##############################

  assign data_in_ready = !data_out_valid || data_out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (data_in_ready) begin
      data_out_valid <= data_in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (data_in_valid && data_in_ready) begin
      data_out.last <= data_in.last;
      for (int l = 0; l < stream_pkg::OUT_LANES; l++) begin
        data_out.lanes[l] <= LUT[data_in.lanes[l]];
      end
    end
  end

  out_stable: assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out));

endmodule

// File: design/roller.sv
`timescale 1ns/1ps

module roller (
  input  logic                  clk,
  input  logic                  rst,
  input  stream_pkg::in_beat_t  data_in,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output stream_pkg::out_beat_t data_out,
  output logic                  data_out_valid,
  input  logic                  data_out_ready
);

  typedef enum logic [1:0] {
    roll_idle,
    roll_first,
    roll_second
  } roll_state_t;

  // Two halves per input beat.
  if (stream_pkg::IN_LANES != 2 * stream_pkg::OUT_LANES) begin : g_lane_check
    $error("roller expects IN_LANES equal to twice OUT_LANES");
  end

  roll_state_t state;
  roll_state_t state_next;
  stream_pkg::in_beat_t held;

  logic take_in;
  logic take_out;

  assign data_out_valid = (state != roll_idle);
  // New beat loads on the edge that takes the high half.
  assign data_in_ready = (state == roll_idle) || ((state == roll_second) && data_out_ready);
  assign take_in = data_in_valid && data_in_ready;
  assign take_out = data_out_valid && data_out_ready;

  always_comb begin
    state_next = state;
    case (state)
      roll_idle: begin
        if (take_in) state_next = roll_first;
      end
      roll_first: begin
        if (take_out) state_next = roll_second;
      end
      roll_second: begin
        if (take_in) state_next = roll_first;
        else if (take_out) state_next = roll_idle;
      end
      default: state_next = roll_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= roll_idle;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      held <= data_in;
    end
  end

  // Low half first, tensor end marked only on the high half.
  always_comb begin
    if (state == roll_second) begin
      data_out.lanes = held.lanes[stream_pkg::IN_LANES-1:stream_pkg::OUT_LANES];
      data_out.last  = held.last;
    end else begin
      data_out.lanes = held.lanes[stream_pkg::OUT_LANES-1:0];
      data_out.last  = 1'b0;
    end
  end

  out_stable: assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out));

endmodule

// File: design/stream_pkg.sv
package stream_pkg;

  // ##############################
  // Stream geometry
  // ##############################

  // Elements per beat on each side of the roller.
  localparam int IN_LANES = 4;
  localparam int OUT_LANES = 2;

  // Input beats held by the front FIFO.
  localparam int FIFO_DEPTH = 4;

  // ##############################
  // Beat formats
  // ##############################

  // Lane 0 sits in the low bits, last on top.
  typedef struct packed {
    logic                                   last;
    act_format_pkg::act_t [IN_LANES-1:0]    lanes;
  } in_beat_t;

  typedef struct packed {
    logic                                   last;
    act_format_pkg::act_t [OUT_LANES-1:0]   lanes;
  } out_beat_t;

endpackage

// File: design/unpacked_fifo.sv
`timescale 1ns/1ps

module unpacked_fifo #(
  parameter int DEPTH = stream_pkg::FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst,
  input  stream_pkg::in_beat_t data_in,
  input  logic                 data_in_valid,
  output logic                 data_in_ready,
  output stream_pkg::in_beat_t data_out,
  output logic                 data_out_valid,
  input  logic                 data_out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  stream_pkg::in_beat_t mem [DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  ptr_t wr_ptr_next;
  ptr_t rd_ptr_next;
  cnt_t count;

  logic push;
  logic load_out;
  logic mem_rd;
  logic mem_wr;
  logic bypass;

  // Output register can take a new head when empty or drained this cycle.
  assign load_out = !data_out_valid || data_out_ready;

  // A full buffer still accepts when its head leaves in the same cycle.
  assign data_in_ready = (count < cnt_t'(DEPTH)) || data_out_ready;
  assign push = data_in_valid && data_in_ready;

  assign mem_rd = load_out && (count != '0);
  // Empty buffer, so the new beat goes straight to the output register.
  assign bypass = load_out && (count == '0) && push;
  assign mem_wr = push && !bypass;

  assign wr_ptr_next = (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_ptr_next = (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      data_out_valid <= 1'b0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr_next;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr_next;
      end
      if (mem_wr && !mem_rd) begin
        count <= count + 1'b1;
      end else if (mem_rd && !mem_wr) begin
        count <= count - 1'b1;
      end
      if (load_out) begin
        data_out_valid <= mem_rd || bypass;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= data_in;
    end
    if (mem_rd) begin
      data_out <= mem[rd_ptr];
    end else if (bypass) begin
      data_out <= data_in;
    end
  end

  count_in_range: assert property (@(posedge clk) disable iff (rst)
    count <= cnt_t'(DEPTH));

endmodule

// File: testbench/tb_fixed_logsigmoid.sv
`timescale 1ns/1ps

module tb_fixed_logsigmoid;

  localparam int CLK_PERIOD = 100;
  localparam int TABLE_LEN = 24;
  localparam int STALL_CYCLES = 20;
  localparam int WATCHDOG_CYCLES = (TABLE_LEN * 2 + 60) * 20;

  localparam int READY_RANDOM = 0;
  localparam int READY_LOW = 1;
  localparam int READY_HIGH = 2;

  logic                  clk;
  logic                  rst;
  stream_pkg::in_beat_t  in_beat;
  logic                  in_valid;
  logic                  in_ready;
  stream_pkg::out_beat_t out_beat;
  logic                  out_valid;
  logic                  out_ready = 1'b0;

  stream_pkg::in_beat_t  stim_table [TABLE_LEN];
  stream_pkg::out_beat_t exp_q [$];

  int   ready_mode = READY_RANDOM;
  int   out_count = 0;
  logic stall_seen = 1'b0;

  fixed_logsigmoid dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ##############################
  // Reference model
  // ##############################

  // ln(1/(1+e^-x)) in Q4.4, halves away from zero, then clamped.
  function automatic act_format_pkg::act_t model_lane(input act_format_pkg::act_t code);
    real scale;
    real x;
    real y;
    real mag;
    int q;
    scale = $itor(1 << act_format_pkg::ACT_FRAC);
    x = $itor($signed(code)) / scale;
    y = scale * $ln(1.0 / (1.0 + $exp(-x)));
    mag = (y < 0.0) ? -y : y;
    q = $rtoi($floor(mag + 0.5));
    if (y < 0.0) q = -q;
    if (q < act_format_pkg::ACT_MIN) q = act_format_pkg::ACT_MIN;
    if (q > act_format_pkg::ACT_MAX) q = act_format_pkg::ACT_MAX;
    return act_format_pkg::act_t'(q);
  endfunction

  task automatic push_expected(input stream_pkg::in_beat_t beat);
    stream_pkg::out_beat_t lo;
    stream_pkg::out_beat_t hi;
    lo.last = 1'b0;
    lo.lanes[0] = model_lane(beat.lanes[0]);
    lo.lanes[1] = model_lane(beat.lanes[1]);
    hi.last = beat.last;
    hi.lanes[0] = model_lane(beat.lanes[2]);
    hi.lanes[1] = model_lane(beat.lanes[3]);
    exp_q.push_back(lo);
    exp_q.push_back(hi);
  endtask

  // ##############################
  // Stimulus table
  // ##############################

  function automatic stream_pkg::in_beat_t make_entry(input int a0, input int a1,
                                                       input int a2, input int a3);
    stream_pkg::in_beat_t entry;
    entry.last = 1'b0;
    entry.lanes[0] = act_format_pkg::act_t'(a0);
    entry.lanes[1] = act_format_pkg::act_t'(a1);
    entry.lanes[2] = act_format_pkg::act_t'(a2);
    entry.lanes[3] = act_format_pkg::act_t'(a3);
    return entry;
  endfunction

  task automatic load_table();
    stim_table[0]  = make_entry(-128, 127, 0, -1);
    stim_table[1]  = make_entry(-127, 126, 1, 2);
    // Near -8, the bottom of the range.
    stim_table[2]  = make_entry(-128, -126, -124, -122);
    stim_table[3]  = make_entry(-120, -127, -125, -123);
    // Large inputs, result rounds to 0.
    stim_table[4]  = make_entry(112, 120, 124, 127);
    stim_table[5]  = make_entry(96, 100, 104, 108);
    stim_table[6]  = make_entry(8, -8, 16, -16);
    stim_table[7]  = make_entry(24, -24, 32, -32);
    stim_table[8]  = make_entry(40, -40, 48, -48);
    stim_table[9]  = make_entry(3, -3, 5, -5);
    stim_table[10] = make_entry(12, -12, 20, -20);
    stim_table[11] = make_entry(64, -64, 80, -80);
    stim_table[12] = make_entry(0, 0, 0, 0);
    stim_table[13] = make_entry(127, 127, -128, -128);
    stim_table[14] = make_entry(1, -1, 2, -2);
    stim_table[15] = make_entry(56, -56, 72, -72);
    stim_table[16] = make_entry(88, -88, 104, -104);
    stim_table[17] = make_entry(10, 11, 13, 14);
    stim_table[18] = make_entry(-10, -11, -13, -14);
    stim_table[19] = make_entry(4, -4, 6, -6);
    stim_table[20] = make_entry(50, -50, 60, -60);
    stim_table[21] = make_entry(115, 116, 117, 118);
    stim_table[22] = make_entry(-100, -90, -70, -30);
    stim_table[23] = make_entry(28, 36, 44, 52);
    // Tensors of four beats.
    for (int i = 0; i < TABLE_LEN; i++) begin
      stim_table[i].last = (i % 4 == 3);
    end
  endtask

  // ##############################
  // Drivers and checks
  // ##############################

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Called on a rising edge, returns on the edge that completes the transfer.
  task automatic send_beat(input stream_pkg::in_beat_t beat);
    logic accepted;
    push_expected(beat);
    in_beat  <= beat;
    in_valid <= 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
    end
  endtask

  task automatic check_output();
    stream_pkg::out_beat_t expected;
    assert (exp_q.size() != 0)
      else abort_run("An output beat appeared while no beat was expected");
    expected = exp_q.pop_front();
    assert (out_beat == expected)
      else abort_run($sformatf(
        "ERR %0t: beat %0d got last=%0b lanes %0d %0d, expected last=%0b lanes %0d %0d",
        $time, out_count, out_beat.last, $signed(out_beat.lanes[0]),
        $signed(out_beat.lanes[1]), expected.last, $signed(expected.lanes[0]),
        $signed(expected.lanes[1])));
    out_count++;
  endtask

  always @(posedge clk) begin
    case (ready_mode)
      READY_LOW:  out_ready <= 1'b0;
      READY_HIGH: out_ready <= 1'b1;
      default:    out_ready <= (($urandom % 100) < 70);
    endcase
  end

  // Sampled mid-cycle, the transfer itself happens on the next rising edge.
  always @(negedge clk) begin
    if (!rst) begin
      if (in_valid && !in_ready) stall_seen = 1'b1;
      if (out_valid && out_ready) check_output();
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    void'($urandom(28));
    rst = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    load_table();

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!out_valid && in_ready)
      else abort_run("DUT is not idle and ready after reset");

    // Table pass under random back-pressure.
    @(posedge clk);
    for (int i = 0; i < TABLE_LEN; i++) begin
      send_beat(stim_table[i]);
    end
    in_valid <= 1'b0;

    // Long stall, then a free-running output.
    @(negedge clk);
    ready_mode = READY_LOW;
    fork
      begin
        repeat (STALL_CYCLES) @(negedge clk);
        ready_mode = READY_HIGH;
      end
    join_none
    @(posedge clk);
    for (int i = 0; i < TABLE_LEN; i++) begin
      send_beat(stim_table[i]);
    end
    in_valid <= 1'b0;

    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (stall_seen)
      else abort_run("in_ready never dropped under back-pressure");
    assert (!out_valid)
      else abort_run("Output still valid after all expected beats were taken");
    $display("Regression passed");
    $finish;
  end

endmodule

// File: verilog.f
design/act_format_pkg.sv
design/stream_pkg.sv
design/unpacked_fifo.sv
design/roller.sv
design/logsigmoid_lut.sv
design/fixed_logsigmoid.sv
testbench/tb_fixed_logsigmoid.sv
